/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // ********************
    // Base widths
    // ********************

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Requests are held by the CPU until the matching hit
    typedef struct packed {
        logic  data_read;
        logic  data_write;
        logic  instr_read;
        addr_t data_addr;
        addr_t instr_addr;
        word_t data_wdata;
    } cpu_req_t;

    // Fetched words are zero outside their hit cycle
    typedef struct packed {
        logic  ihit;
        logic  dhit;
        word_t fetched_data;
        word_t fetched_instr;
    } cpu_rsp_t;

endpackage

/* rtl/bus_pkg.sv */
package bus_pkg;

    typedef logic [3:0] sel_t;

    // ********************
    // Request unit <-> manager
    // ********************

    // read and write are single-cycle pulses
    typedef struct packed {
        logic           read;
        logic           write;
        cpu_pkg::addr_t adr;
        cpu_pkg::word_t dat;
    } bus_cmd_t;

    typedef struct packed {
        logic           busy;
        cpu_pkg::word_t dat;
    } bus_rsp_t;

    // ********************
    // Wishbone classic
    // ********************

    typedef struct packed {
        logic           cyc;
        logic           stb;
        logic           we;
        cpu_pkg::addr_t adr;
        cpu_pkg::word_t dat;
        sel_t           sel;
    } wb_req_t;

    typedef struct packed {
        logic           ack;
        cpu_pkg::word_t dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        ARM,
        CYCLE,
        DONE
    } mgr_state_t;

endpackage

/* rtl/request_unit.sv */
`timescale 1ns/1ps

module request_unit (
    input  logic              clk,
    input  logic              nRST,
    // CPU side
    input  cpu_pkg::cpu_req_t cpu_req_i,
    output cpu_pkg::cpu_rsp_t cpu_rsp_o,
    // Bus manager side
    input  bus_pkg::bus_rsp_t bus_rsp_i,
    output bus_pkg::bus_cmd_t bus_cmd_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_READ_DATA,
        READ_DATA,
        WAIT_READ_INSTR,
        READ_INSTR,
        WAIT_WRITE_DATA,
        WRITE_DATA
    } req_state_t;

    req_state_t        state;
    req_state_t        next_state;

    bus_pkg::bus_cmd_t cmd_q;
    bus_pkg::bus_cmd_t next_cmd;

    cpu_pkg::cpu_rsp_t rsp_q;
    cpu_pkg::cpu_rsp_t next_rsp;

    assign bus_cmd_o = cmd_q;
    assign cpu_rsp_o = rsp_q;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            cmd_q <= '0;
            rsp_q <= '0;
        end else begin
            state <= next_state;
            cmd_q <= next_cmd;
            rsp_q <= next_rsp;
        end
    end

    // ********************
    // Next state and outputs
    // ********************

    always_comb begin
        next_state = state;
        next_cmd   = '0;
        next_rsp   = '0;
        case (state)
            IDLE: begin
                // A request whose hit is showing this cycle is already served
                if (cpu_req_i.data_read && !rsp_q.dhit) begin
                    next_cmd.read  = 1'b1;
                    next_cmd.adr   = cpu_req_i.data_addr;
                    next_state     = WAIT_READ_DATA;
                end else if (cpu_req_i.data_write && !rsp_q.dhit) begin
                    next_cmd.write = 1'b1;
                    next_cmd.adr   = cpu_req_i.data_addr;
                    next_cmd.dat   = cpu_req_i.data_wdata;
                    next_state     = WAIT_WRITE_DATA;
                end else if (cpu_req_i.instr_read && !rsp_q.ihit) begin
                    next_cmd.read  = 1'b1;
                    next_state     = WAIT_READ_INSTR;
                end
            end
            WAIT_READ_DATA: begin
                next_cmd.adr = cmd_q.adr;
                next_state   = READ_DATA;
            end
            READ_DATA: begin
                if (bus_rsp_i.busy) begin
                    next_cmd.adr = cmd_q.adr;
                end else begin
                    next_rsp.dhit         = 1'b1;
                    next_rsp.fetched_data = bus_rsp_i.dat;
                    next_state            = IDLE;
                end
            end
            WAIT_READ_INSTR: begin
                // Instruction address goes out one cycle after the pulse
                next_cmd.adr = cpu_req_i.instr_addr;
                next_state   = READ_INSTR;
            end
            READ_INSTR: begin
                if (bus_rsp_i.busy) begin
                    next_cmd.adr = cmd_q.adr;
                end else begin
                    next_rsp.ihit          = 1'b1;
                    next_rsp.fetched_instr = bus_rsp_i.dat;
                    next_state             = IDLE;
                end
            end
            WAIT_WRITE_DATA: begin
                next_cmd.adr = cmd_q.adr;
                next_cmd.dat = cmd_q.dat;
                next_state   = WRITE_DATA;
            end
            WRITE_DATA: begin
                if (bus_rsp_i.busy) begin
                    next_cmd.adr = cmd_q.adr;
                    next_cmd.dat = cmd_q.dat;
                end else begin
                    next_rsp.dhit = 1'b1;
                    next_state    = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* rtl/wishbone_manager.sv */
`timescale 1ns/1ps

module wishbone_manager (
    input  logic              clk,
    input  logic              nRST,
    // Request unit side
    input  bus_pkg::bus_cmd_t bus_cmd_i,
    output bus_pkg::bus_rsp_t bus_rsp_o,
    // Wishbone side
    output bus_pkg::wb_req_t  wb_req_o,
    input  bus_pkg::wb_rsp_t  wb_rsp_i
);

    bus_pkg::mgr_state_t state;

    logic                busy_q;
    logic                cyc_q;
    logic                we_q;
    cpu_pkg::addr_t      adr_q;
    cpu_pkg::word_t      dat_q;
    cpu_pkg::word_t      rdat_q;

    assign bus_rsp_o.busy = busy_q;
    assign bus_rsp_o.dat  = rdat_q;

    // Single cycles only, so stb follows cyc
    assign wb_req_o.cyc = cyc_q;
    assign wb_req_o.stb = cyc_q;
    assign wb_req_o.we  = we_q;
    assign wb_req_o.adr = adr_q;
    assign wb_req_o.dat = dat_q;
    assign wb_req_o.sel = '1;

    // ********************
    // Cycle control
    // ********************

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state  <= bus_pkg::IDLE;
            busy_q <= 1'b0;
            cyc_q  <= 1'b0;
            we_q   <= 1'b0;
        end else begin
            case (state)
                bus_pkg::IDLE: begin
                    if (bus_cmd_i.read || bus_cmd_i.write) begin
                        busy_q <= 1'b1;
                        we_q   <= bus_cmd_i.write;
                        state  <= bus_pkg::ARM;
                    end
                end
                bus_pkg::ARM: begin
                    cyc_q <= 1'b1;
                    state <= bus_pkg::CYCLE;
                end
                bus_pkg::CYCLE: begin
                    if (wb_rsp_i.ack) begin
                        cyc_q  <= 1'b0;
                        busy_q <= 1'b0;
                        state  <= bus_pkg::DONE;
                    end
                end
                bus_pkg::DONE: begin
                    state <= bus_pkg::IDLE;
                end
                default: begin
                    state <= bus_pkg::IDLE;
                end
            endcase
        end
    end

    // Address and data settle one cycle after the pulse
    always_ff @(posedge clk) begin
        if (state == bus_pkg::ARM) begin
            adr_q <= bus_cmd_i.adr;
            dat_q <= bus_cmd_i.dat;
        end
        if (state == bus_pkg::CYCLE && wb_rsp_i.ack && !we_q) begin
            rdat_q <= wb_rsp_i.dat;
        end
    end

endmodule

/* rtl/wb_ram.sv */
`timescale 1ns/1ps

module wb_ram #(
    parameter int RAM_DEPTH   = 256,
    parameter int WAIT_STATES = 2
) (
    input  logic             clk,
    input  logic             nRST,
    input  bus_pkg::wb_req_t wb_req_i,
    output bus_pkg::wb_rsp_t wb_rsp_o
);

    // ack is registered, so one wait state is the floor
    localparam int ACK_DELAY = (WAIT_STATES < 1) ? 1 : WAIT_STATES;
    localparam int CNT_W     = $clog2(ACK_DELAY + 1);
    localparam int IDX_W     = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    cpu_pkg::word_t   mem [RAM_DEPTH];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] wait_cnt;
    logic             ack_q;
    logic             access;
    logic             ack_fire;
    cpu_pkg::word_t   rdat_q;

    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Word index wraps at RAM_DEPTH
    assign idx      = IDX_W'(wb_req_i.adr[31:2] % RAM_DEPTH);
    assign access   = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign ack_fire = access && (wait_cnt == CNT_W'(ACK_DELAY - 1));

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdat_q;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            ack_q    <= 1'b0;
            wait_cnt <= '0;
        end else if (ack_q || !access) begin
            ack_q    <= 1'b0;
            wait_cnt <= '0;
        end else if (ack_fire) begin
            ack_q    <= 1'b1;
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // Write lands with the edge that raises ack
    always_ff @(posedge clk) begin
        if (ack_fire) begin
            rdat_q <= mem[idx];
            if (wb_req_i.we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_req_i.sel[b]) mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
            end
        end
    end

endmodule

/* rtl/memory_port_top.sv */
`timescale 1ns/1ps

module memory_port_top #(
    parameter int RAM_DEPTH   = 256,
    parameter int WAIT_STATES = 2
) (
    input  logic              clk,
    input  logic              nRST,
    input  cpu_pkg::cpu_req_t cpu_req_i,
    output cpu_pkg::cpu_rsp_t cpu_rsp_o
);

    // ********************
    // Internal buses
    // ********************

    bus_pkg::bus_cmd_t bus_cmd;
    bus_pkg::bus_rsp_t bus_rsp;
    bus_pkg::wb_req_t  wb_req;
    bus_pkg::wb_rsp_t  wb_rsp;

    request_unit u_request_unit (
        .clk       (clk),
        .nRST      (nRST),
        .cpu_req_i (cpu_req_i),
        .cpu_rsp_o (cpu_rsp_o),
        .bus_rsp_i (bus_rsp),
        .bus_cmd_o (bus_cmd)
    );

    wishbone_manager u_wishbone_manager (
        .clk       (clk),
        .nRST      (nRST),
        .bus_cmd_i (bus_cmd),
        .bus_rsp_o (bus_rsp),
        .wb_req_o  (wb_req),
        .wb_rsp_i  (wb_rsp)
    );

    wb_ram #(
        .RAM_DEPTH   (RAM_DEPTH),
        .WAIT_STATES (WAIT_STATES)
    ) u_wb_ram (
        .clk      (clk),
        .nRST     (nRST),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held low for 8 rising edges
    initial begin
        nRST = 1'b0;
        repeat (8) @(posedge clk);
        #1 nRST = 1'b1;
    end

endmodule

/* dv/memory_port_props.sv */
`timescale 1ns/1ps

module memory_port_props (
    input logic              clk,
    input logic              nRST,
    input cpu_pkg::cpu_rsp_t cpu_rsp,
    input bus_pkg::wb_req_t  wb_req,
    input bus_pkg::wb_rsp_t  wb_rsp
);

    // ********************
    // Hit pulses
    // ********************

    dhit_one_cycle: assert property (@(posedge clk) disable iff (!nRST)
        cpu_rsp.dhit |=> !cpu_rsp.dhit)
        else $error("dhit held for more than one cycle");

    ihit_one_cycle: assert property (@(posedge clk) disable iff (!nRST)
        cpu_rsp.ihit |=> !cpu_rsp.ihit)
        else $error("ihit held for more than one cycle");

    hits_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(cpu_rsp.dhit && cpu_rsp.ihit))
        else $error("dhit and ihit high together");

    // ********************
    // Wishbone handshake
    // ********************

    stb_held_to_ack: assert property (@(posedge clk) disable iff (!nRST)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && wb_req.cyc))
        else $error("stb dropped before ack");

endmodule

bind memory_port_top memory_port_props u_props (
    .clk     (clk),
    .nRST    (nRST),
    .cpu_rsp (cpu_rsp_o),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp)
);

/* dv/tb_memory_port.sv */
`timescale 1ns/1ps

module tb_memory_port;

    localparam int RAM_DEPTH   = 256;
    localparam int WAIT_STATES = 2;

    logic              clk;
    logic              nRST;
    cpu_pkg::cpu_req_t cpu_req;
    cpu_pkg::cpu_rsp_t cpu_rsp_o;

    string          names[$];
    string          ops[$];
    cpu_pkg::addr_t daddrs[$];
    cpu_pkg::addr_t iaddrs[$];
    cpu_pkg::word_t wdatas[$];
    cpu_pkg::word_t exp_ds[$];
    cpu_pkg::word_t exp_is[$];

    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int watchdog_cycles = 0;
    bit watchdog_armed = 1'b0;

    tb_clk_gen u_clk_gen (
        .clk  (clk),
        .nRST (nRST)
    );

    memory_port_top #(
        .RAM_DEPTH   (RAM_DEPTH),
        .WAIT_STATES (WAIT_STATES)
    ) uut (
        .clk       (clk),
        .nRST      (nRST),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp_o)
    );

    // ********************
    // Compare tasks
    // ********************

    task automatic check_word(string name, cpu_pkg::word_t exp, cpu_pkg::word_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // First hit of a paired request must be the data hit alone
    task automatic check_order(string name, cpu_pkg::cpu_rsp_t first_rsp);
        if (!(first_rsp.dhit && !first_rsp.ihit)) begin
            $display("** Error: %s expected dhit first actual dhit=%b ihit=%b",
                     name, first_rsp.dhit, first_rsp.ihit);
            errors++;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic read_stimulus();
        int    fd;
        int    n;
        string line;
        string name;
        string op;
        cpu_pkg::word_t f[5];
        fd = $fopen("dv/memory_port_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/memory_port_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h",
                            name, op, f[0], f[1], f[2], f[3], f[4]);
                if (n == 7) begin
                    names.push_back(name);
                    ops.push_back(op);
                    daddrs.push_back(f[0]);
                    iaddrs.push_back(f[1]);
                    wdatas.push_back(f[2]);
                    exp_ds.push_back(f[3]);
                    exp_is.push_back(f[4]);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_reset();
        int errs_before;
        errs_before = errors;
        repeat (12) begin
            @(negedge clk);
            check_word("reset hits", '0, cpu_pkg::word_t'({cpu_rsp_o.ihit, cpu_rsp_o.dhit}));
            check_word("reset fetched_data", '0, cpu_rsp_o.fetched_data);
            check_word("reset fetched_instr", '0, cpu_rsp_o.fetched_instr);
        end
        report_test("reset", errs_before);
    endtask

    task automatic run_op(int i);
        cpu_pkg::cpu_rsp_t first_rsp;
        cpu_pkg::word_t    dword;
        cpu_pkg::word_t    iword;
        bit                need_d;
        bit                need_i;
        bit                got_d;
        bit                got_i;
        int                errs_before;
        errs_before = errors;
        need_d = (ops[i] != "I");
        need_i = (ops[i] == "I") || (ops[i] == "DI");
        got_d = 1'b0;
        got_i = 1'b0;
        first_rsp = '0;
        dword = '0;
        iword = '0;
        @(posedge clk);
        #1;
        cpu_req = '0;
        cpu_req.data_read  = (ops[i] == "R") || (ops[i] == "DI");
        cpu_req.data_write = (ops[i] == "W");
        cpu_req.instr_read = need_i;
        cpu_req.data_addr  = daddrs[i];
        cpu_req.instr_addr = iaddrs[i];
        cpu_req.data_wdata = wdatas[i];
        while ((need_d && !got_d) || (need_i && !got_i)) begin
            @(negedge clk);
            if (cpu_rsp_o.dhit || cpu_rsp_o.ihit) begin
                if (!got_d && !got_i) begin
                    first_rsp = cpu_rsp_o;
                end
                if (cpu_rsp_o.dhit) begin
                    got_d = 1'b1;
                    dword = cpu_rsp_o.fetched_data;
                end
                if (cpu_rsp_o.ihit) begin
                    got_i = 1'b1;
                    iword = cpu_rsp_o.fetched_instr;
                end
                @(posedge clk);
                #1;
                if (got_d) begin
                    cpu_req.data_read  = 1'b0;
                    cpu_req.data_write = 1'b0;
                end
                if (got_i) begin
                    cpu_req.instr_read = 1'b0;
                end
            end
        end
        if (ops[i] == "R" || ops[i] == "DI") begin
            check_word({names[i], " data"}, exp_ds[i], dword);
        end
        if (need_i) begin
            check_word({names[i], " instr"}, exp_is[i], iword);
        end
        if (ops[i] == "DI") begin
            check_order(names[i], first_rsp);
        end
        report_test(names[i], errs_before);
    endtask

    // ********************
    // Main sequence
    // ********************

    initial begin
        cpu_req = '0;
        read_stimulus();
        watchdog_cycles = names.size() * (WAIT_STATES + 10) + 50;
        watchdog_armed = 1'b1;
        check_reset();
        for (int i = 0; i < names.size(); i++) begin
            run_op(i);
        end
        if (names.size() == 0) begin
            $display("no operations were read from the stimulus file");
            errors++;
        end
        $display("tests: %0d  passed: %0d  failed: %0d  errors: %0d",
                 tests, tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (watchdog_armed);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

/* dv/memory_port_stimulus.txt */
# name op data_addr instr_addr wdata exp_data exp_instr (hex)
# op: R data read, W data write, I instruction fetch, DI data read and fetch together
rd_unwritten    R  00000010 00000000 00000000 00000000 00000000
wr_a            W  00000010 00000000 deadbeef 00000000 00000000
rd_a            R  00000010 00000000 00000000 deadbeef 00000000
wr_b            W  00000014 00000000 cafef00d 00000000 00000000
rd_b            R  00000014 00000000 00000000 cafef00d 00000000
wr_a_again      W  00000010 00000000 12345678 00000000 00000000
rd_a_again      R  00000010 00000000 00000000 12345678 00000000
rd_b_kept       R  00000014 00000000 00000000 cafef00d 00000000
wr_instr0       W  00000100 00000000 00a00093 00000000 00000000
fetch_instr0    I  00000000 00000100 00000000 00000000 00a00093
wr_instr1       W  00000104 00000000 00108113 00000000 00000000
fetch_unwritten I  00000000 00000200 00000000 00000000 00000000
pair_priority   DI 00000014 00000104 00000000 cafef00d 00108113
pair_same_word  DI 00000100 00000100 00000000 00a00093 00a00093
wrap_wr_high    W  00000420 00000000 a5a55a5a 00000000 00000000
wrap_rd_low     R  00000020 00000000 00000000 a5a55a5a 00000000
wr_last_word    W  000003fc 00000000 0badc0de 00000000 00000000
wrap_rd_top     R  000007fc 00000000 00000000 0badc0de 00000000
wrap_fetch      I  00000000 00000820 00000000 00000000 a5a55a5a
rd_zero_word    R  00000000 00000000 00000000 00000000 00000000

/* filelist.f */
rtl/cpu_pkg.sv
rtl/bus_pkg.sv
rtl/request_unit.sv
rtl/wishbone_manager.sv
rtl/wb_ram.sv
rtl/memory_port_top.sv
dv/tb_clk_gen.sv
dv/memory_port_props.sv
dv/tb_memory_port.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory port testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module tb_memory_port -f filelist.f -o sim_memory_port
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_memory_port)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1
